//--- filelist.f
rtl/mm_types_pkg.sv
rtl/mem_bus_pkg.sv
rtl/dma_reader.sv
rtl/mm_engine.sv
rtl/dma_writer.sv
rtl/dma_ctrl.sv
rtl/matmul_accel_top.sv
verification/matmul_accel_props.sv
verification/tb_matmul_accel.sv

//--- verification/tb_matmul_accel.sv
// testbench for the matrix-multiply accelerator
// memory model with random stalls and A/B beat reordering
// reference multiply, write-beat checker, cycle timeout
`timescale 1ns/1ps
`default_nettype none

module tb_matmul_accel;

    localparam int N         = 4;
    localparam int MEM_WORDS = 256;
    localparam int N_JOBS    = 3;
    // one job at the heaviest stall level stays far below this
    localparam int JOB_BUDGET     = 1000;
    localparam int TIMEOUT_CYCLES = N_JOBS * JOB_BUDGET;

    logic        clk;
    logic        rst_n      = 1'b0;
    logic        start      = 1'b0;
    logic [31:0] mat_a_addr = '0;
    logic [31:0] mat_b_addr = '0;
    logic [31:0] mat_c_addr = '0;
    logic        done;

    mem_bus_pkg::rd_addr_t ar_req;
    logic                  ar_valid;
    logic                  ar_ready = 1'b0;
    mem_bus_pkg::rd_data_t r_beat   = '0;
    logic                  r_valid  = 1'b0;
    logic                  r_ready;
    mem_bus_pkg::wr_addr_t aw_req;
    logic                  aw_valid;
    logic                  aw_ready = 1'b0;
    mem_bus_pkg::wr_data_t w_data;
    logic                  w_valid;
    logic                  w_ready  = 1'b0;
    logic                  b_valid  = 1'b0;
    logic                  b_ready;

    // memory model
    logic [31:0] mem [MEM_WORDS];
    logic [31:0] lcg_state = 32'hda95;
    // 0 random ids, 1 alternate ids, 2 B ahead of A
    int          rd_mode   = 0;
    // stall chance in sixteenths
    int          gap_lvl   = 0;
    int          rd_word [2];
    int          rd_left [2];
    int          last_id   = 0;
    int          wr_word   = 0;
    logic        b_pending = 1'b0;
    int          ar_total  = 0;
    int          b_hs_cycle = 0;

    // checker
    mm_types_pkg::c_tile_t exp_c   = '0;
    logic [3:0]            w_idx   = '0;
    int                    w_total = 0;
    int                    errors  = 0;
    int                    cycle   = 0;

    matmul_accel_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .mat_a_addr_i (mat_a_addr),
        .mat_b_addr_i (mat_b_addr),
        .mat_c_addr_i (mat_c_addr),
        .start_i      (start),
        .done_o       (done),
        .ar_o         (ar_req),
        .ar_valid_o   (ar_valid),
        .ar_ready_i   (ar_ready),
        .r_i          (r_beat),
        .r_valid_i    (r_valid),
        .r_ready_o    (r_ready),
        .aw_o         (aw_req),
        .aw_valid_o   (aw_valid),
        .aw_ready_i   (aw_ready),
        .w_o          (w_data),
        .w_valid_o    (w_valid),
        .w_ready_i    (w_ready),
        .b_valid_i    (b_valid),
        .b_ready_o    (b_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // true with a chance of num16/16
    function automatic logic coin(input int num16);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[31:28]) < num16;
    endfunction

    // C = A x B, signed 16-bit elements from the low half of each word, sum mod 2^32
    function automatic mm_types_pkg::c_tile_t ref_matmul(input int a_word, input int b_word);
        mm_types_pkg::c_tile_t c;
        int sum;
        int ea;
        int eb;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                sum = 0;
                for (int k = 0; k < N; k++) begin
                    ea  = int'($signed(mem[a_word + i*N + k][15:0]));
                    eb  = int'($signed(mem[b_word + k*N + j][15:0]));
                    sum = sum + ea * eb;
                end
                c[i*N+j] = sum;
            end
        end
        return c;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error: t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic fill_memory();
        int w;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = lcg_next() ^ 32'(i);
        end
        // job 2: row 0 of A and column 0 of B at -32768, C[0][0] wraps to 0
        for (int k = 0; k < N; k++) begin
            w = (32'h100 >> 2) + k;
            mem[w] = {mem[w][31:16], 16'h8000};
            w = (32'h140 >> 2) + k*N;
            mem[w] = {mem[w][31:16], 16'h8000};
        end
    endtask

    // memory model, all five channels
    always @(posedge clk) begin : mem_model
        int id;
        if (!rst_n) begin
            ar_ready   <= 1'b0;
            r_valid    <= 1'b0;
            aw_ready   <= 1'b0;
            w_ready    <= 1'b0;
            b_valid    <= 1'b0;
            rd_left[0] = 0;
            rd_left[1] = 0;
            rd_word[0] = 0;
            rd_word[1] = 0;
            b_pending  = 1'b0;
        end else begin
            // A address first, then B
            if (ar_valid && ar_ready) begin
                check_value("ar_o.id", ar_req.id,
                            ar_total[0] ? mem_bus_pkg::ID_B : mem_bus_pkg::ID_A);
                check_value("ar_o.addr", ar_req.addr, ar_total[0] ? mat_b_addr : mat_a_addr);
                check_value("ar_o.len", ar_req.len, 32'd15);
                rd_word[ar_req.id] = ar_req.addr >> 2;
                rd_left[ar_req.id] = ar_req.len + 1;
                ar_total++;
            end
            ar_ready <= !coin(gap_lvl);

            if (r_valid && r_ready) begin
                id = int'(r_beat.id);
                rd_word[id]++;
                rd_left[id]--;
            end
            // r beat held until taken, otherwise free to choose
            if (!r_valid || r_ready) begin
                if ((rd_left[0] > 0 || rd_left[1] > 0) && !coin(gap_lvl)) begin
                    if (rd_left[0] == 0) begin
                        id = 1;
                    end else if (rd_left[1] == 0) begin
                        id = 0;
                    end else begin
                        case (rd_mode)
                            0: id = coin(8) ? 1 : 0;
                            1: id = (last_id == 0) ? 1 : 0;
                            default: id = 1;
                        endcase
                    end
                    r_beat.data <= mem[rd_word[id]];
                    r_beat.id   <= mem_bus_pkg::id_t'(id);
                    r_beat.last <= (rd_left[id] == 1);
                    r_valid     <= 1'b1;
                    last_id = id;
                end else begin
                    r_valid <= 1'b0;
                end
            end

            if (aw_valid && aw_ready) begin
                check_value("aw_o.addr", aw_req.addr, mat_c_addr);
                check_value("aw_o.len", aw_req.len, 32'd15);
                wr_word = aw_req.addr >> 2;
            end
            aw_ready <= !coin(gap_lvl);

            // C words recorded in memory
            if (w_valid && w_ready) begin
                mem[wr_word] = w_data.data;
                wr_word++;
                if (w_data.last) begin
                    b_pending = 1'b1;
                end
            end
            w_ready <= !coin(gap_lvl);

            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
                b_hs_cycle = cycle;
            end else if (b_pending && !b_valid && !coin(gap_lvl)) begin
                b_valid <= 1'b1;
                b_pending = 1'b0;
            end
        end
    end

    // each w beat against the reference tile
    always @(posedge clk) begin
        if (rst_n && w_valid && w_ready) begin
            check_value("w_o.data", w_data.data, exp_c[w_idx]);
            check_value("w_o.last", w_data.last, w_idx == 4'd15);
            w_idx   <= w_idx + 1'b1;
            w_total <= w_total + 1;
        end
    end

    // cycle count and timeout
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: jobs did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d", errors);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic run_job(input int job, input logic [31:0] a_addr, input logic [31:0] b_addr,
                           input logic [31:0] c_addr, input int mode, input int gaps);
        @(posedge clk);
        check_value("done_o", done, 1'b1);
        exp_c      <= ref_matmul(a_addr >> 2, b_addr >> 2);
        rd_mode    <= mode;
        gap_lvl    <= gaps;
        mat_a_addr <= a_addr;
        mat_b_addr <= b_addr;
        mat_c_addr <= c_addr;
        start      <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        check_value("done_o", done, 1'b0);
        // start while busy is ignored
        if (job == 1) begin
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
        end
        do begin
            @(posedge clk);
        end while (done !== 1'b1);
        // done back one cycle after the b handshake
        check_value("done_o rise cycle", cycle, b_hs_cycle + 1);
        check_value("ar handshakes", ar_total, 2 * (job + 1));
        check_value("w handshakes", w_total, 16 * (job + 1));
        for (int i = 0; i < N*N; i++) begin
            check_value("mem C word", mem[(c_addr >> 2) + i], exp_c[i]);
        end
    endtask

    initial begin
        fill_memory();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        // idle outputs straight after reset
        check_value("done_o", done, 1'b1);
        check_value("ar_valid_o", ar_valid, 1'b0);
        check_value("r_ready_o", r_ready, 1'b0);
        check_value("aw_valid_o", aw_valid, 1'b0);
        check_value("w_valid_o", w_valid, 1'b0);
        check_value("b_ready_o", b_ready, 1'b0);
        // random interleave with mild stalls
        run_job(0, 32'h000, 32'h040, 32'h200, 0, 5);
        // no stalls, id alternates every beat
        run_job(1, 32'h080, 32'h0c0, 32'h240, 1, 0);
        // B ahead of A, heavy stalls, wrap case
        run_job(2, 32'h100, 32'h140, 32'h280, 2, 9);
        repeat (4) @(posedge clk);
        $display("errors: %0d value, %0d assertion", errors, dut.u_props.assert_fails);
        if (errors == 0 && dut.u_props.assert_fails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/matmul_accel_props.sv
// concurrent checks bound to the accelerator top level
// payload stability under back-pressure, done against wvalid, wlast position
`timescale 1ns/1ps
`default_nettype none

module matmul_accel_props (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire mem_bus_pkg::rd_addr_t   ar_o,
    input  wire                          ar_valid_o,
    input  wire                          ar_ready_i,
    input  wire mem_bus_pkg::wr_addr_t   aw_o,
    input  wire                          aw_valid_o,
    input  wire                          aw_ready_i,
    input  wire mem_bus_pkg::wr_data_t   w_o,
    input  wire                          w_valid_o,
    input  wire                          w_ready_i,
    input  wire                          done_o
);

    // read by the testbench at the end of the run
    int         assert_fails = 0;
    // w handshakes within the current burst
    logic [3:0] w_beat_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w_beat_q <= '0;
        end else if (w_valid_o && w_ready_i) begin
            w_beat_q <= w_beat_q + 1'b1;
        end
    end

    // valid and payload held until accepted
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
        else begin
            $error("ar valid or payload changed while arready low");
            assert_fails++;
        end

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o))
        else begin
            $error("aw valid or payload changed while awready low");
            assert_fails++;
        end

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_o))
        else begin
            $error("w valid or payload changed while wready low");
            assert_fails++;
        end

    // job still in flight while data goes out
    busy_on_w: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid_o |-> !done_o)
        else begin
            $error("done_o high while wvalid high");
            assert_fails++;
        end

    // wlast only on beat 16
    last_pos: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid_o |-> (w_o.last == (w_beat_q == 4'd15)))
        else begin
            $error("wlast not on the 16th beat");
            assert_fails++;
        end

endmodule

bind matmul_accel_top matmul_accel_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_o       (ar_o),
    .ar_valid_o (ar_valid_o),
    .ar_ready_i (ar_ready_i),
    .aw_o       (aw_o),
    .aw_valid_o (aw_valid_o),
    .aw_ready_i (aw_ready_i),
    .w_o        (w_o),
    .w_valid_o  (w_valid_o),
    .w_ready_i  (w_ready_i),
    .done_o     (done_o)
);

`default_nettype wire

//--- rtl/matmul_accel_top.sv
// matrix-multiply accelerator top level
// sequencer, read DMA, multiply engine and write DMA on one memory bus
`timescale 1ns/1ps
`default_nettype none

module matmul_accel_top (
    input  wire                            clk,
    input  wire                            rst_n,
    // configuration
    input  wire [mem_bus_pkg::ADDR_W-1:0]  mat_a_addr_i,
    input  wire [mem_bus_pkg::ADDR_W-1:0]  mat_b_addr_i,
    input  wire [mem_bus_pkg::ADDR_W-1:0]  mat_c_addr_i,
    input  wire                            start_i,
    output logic                           done_o,
    // read channels
    output mem_bus_pkg::rd_addr_t          ar_o,
    output logic                           ar_valid_o,
    input  wire                            ar_ready_i,
    input  wire mem_bus_pkg::rd_data_t     r_i,
    input  wire                            r_valid_i,
    output logic                           r_ready_o,
    // write channels
    output mem_bus_pkg::wr_addr_t          aw_o,
    output logic                           aw_valid_o,
    input  wire                            aw_ready_i,
    output mem_bus_pkg::wr_data_t          w_o,
    output logic                           w_valid_o,
    input  wire                            w_ready_i,
    input  wire                            b_valid_i,
    output logic                           b_ready_o
);

    logic                  rd_start;
    logic                  mm_start;
    logic                  wr_start;
    logic                  rd_done;
    logic                  mm_done;
    logic                  wr_done;
    logic                  buf_wr_en;
    mm_types_pkg::buf_wr_t buf_wr;
    mm_types_pkg::c_tile_t c_tile;

    dma_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start_i),
        .rd_done_i  (rd_done),
        .mm_done_i  (mm_done),
        .wr_done_i  (wr_done),
        .done_o     (done_o),
        .rd_start_o (rd_start),
        .mm_start_o (mm_start),
        .wr_start_o (wr_start)
    );

    // A and B in, rows to the engine
    dma_reader u_reader (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (rd_start),
        .mat_a_addr_i (mat_a_addr_i),
        .mat_b_addr_i (mat_b_addr_i),
        .ar_o         (ar_o),
        .ar_valid_o   (ar_valid_o),
        .ar_ready_i   (ar_ready_i),
        .r_i          (r_i),
        .r_valid_i    (r_valid_i),
        .r_ready_o    (r_ready_o),
        .buf_wr_o     (buf_wr),
        .buf_wr_en_o  (buf_wr_en),
        .done_o       (rd_done)
    );

    mm_engine u_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .buf_wr_i    (buf_wr),
        .buf_wr_en_i (buf_wr_en),
        .start_i     (mm_start),
        .done_o      (mm_done),
        .tile_o      (c_tile)
    );

    // C tile out
    dma_writer u_writer (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (wr_start),
        .mat_c_addr_i (mat_c_addr_i),
        .tile_i       (c_tile),
        .aw_o         (aw_o),
        .aw_valid_o   (aw_valid_o),
        .aw_ready_i   (aw_ready_i),
        .w_o          (w_o),
        .w_valid_o    (w_valid_o),
        .w_ready_i    (w_ready_i),
        .b_valid_i    (b_valid_i),
        .b_ready_o    (b_ready_o),
        .done_o       (wr_done)
    );

endmodule

`default_nettype wire

//--- rtl/dma_ctrl.sv
// job sequencer
// idle, load, compute, store; each done pulse starts the next stage
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  start_i,
    input  wire  rd_done_i,
    input  wire  mm_done_i,
    input  wire  wr_done_i,
    output logic done_o,
    output logic rd_start_o,
    output logic mm_start_o,
    output logic wr_start_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_COMPUTE,
        S_STORE
    } ctrl_state_e;

    ctrl_state_e state_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= S_IDLE;
            rd_start_o <= 1'b0;
            mm_start_o <= 1'b0;
            wr_start_o <= 1'b0;
        end else begin
            // start pulses last one cycle
            rd_start_o <= 1'b0;
            mm_start_o <= 1'b0;
            wr_start_o <= 1'b0;
            case (state_q)
                // start only taken while idle
                S_IDLE: begin
                    if (start_i) begin
                        state_q    <= S_LOAD;
                        rd_start_o <= 1'b1;
                    end
                end
                S_LOAD: begin
                    if (rd_done_i) begin
                        state_q    <= S_COMPUTE;
                        mm_start_o <= 1'b1;
                    end
                end
                S_COMPUTE: begin
                    if (mm_done_i) begin
                        state_q    <= S_STORE;
                        wr_start_o <= 1'b1;
                    end
                end
                S_STORE: begin
                    if (wr_done_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // high only while idle
    assign done_o = (state_q == S_IDLE);

endmodule

`default_nettype wire

//--- rtl/dma_writer.sv
// write side of the DMA
// write address, 16 result beats with wlast, write response
`timescale 1ns/1ps
`default_nettype none

module dma_writer (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            start_i,
    input  wire [mem_bus_pkg::ADDR_W-1:0]  mat_c_addr_i,
    input  wire mm_types_pkg::c_tile_t     tile_i,
    output mem_bus_pkg::wr_addr_t          aw_o,
    output logic                           aw_valid_o,
    input  wire                            aw_ready_i,
    output mem_bus_pkg::wr_data_t          w_o,
    output logic                           w_valid_o,
    input  wire                            w_ready_i,
    input  wire                            b_valid_i,
    output logic                           b_ready_o,
    output logic                           done_o
);

    localparam int BEAT_W = $clog2(mem_bus_pkg::BURST_LEN);

    typedef enum logic [1:0] {
        W_IDLE,
        W_ADDR,
        W_DATA,
        W_RESP
    } wr_state_e;

    wr_state_e         state_q;
    // row-major index into the tile
    logic [BEAT_W-1:0] beat_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= W_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                W_IDLE: begin
                    if (start_i) begin
                        state_q <= W_ADDR;
                        beat_q  <= '0;
                    end
                end
                W_ADDR: begin
                    if (aw_ready_i) begin
                        state_q <= W_DATA;
                    end
                end
                // wvalid stays up through wready gaps
                W_DATA: begin
                    if (w_ready_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (w_o.last) begin
                            state_q <= W_RESP;
                        end
                    end
                end
                // response accepted, bresp ignored
                W_RESP: begin
                    if (b_valid_i) begin
                        state_q <= W_IDLE;
                    end
                end
                default: state_q <= W_IDLE;
            endcase
        end
    end

    always_comb begin
        aw_o.addr = mat_c_addr_i;
        aw_o.len  = mem_bus_pkg::len_t'(mem_bus_pkg::BURST_LEN - 1);
        w_o.data  = tile_i[beat_q];
        w_o.last  = (beat_q == BEAT_W'(mem_bus_pkg::BURST_LEN - 1));
    end

    assign aw_valid_o = (state_q == W_ADDR);
    assign w_valid_o  = (state_q == W_DATA);
    assign b_ready_o  = (state_q == W_RESP);
    // pulse on the b handshake itself
    assign done_o     = (state_q == W_RESP) && b_valid_i;

endmodule

`default_nettype wire

//--- rtl/mm_engine.sv
// multiply engine
// operand row buffers for A and B
// 4x4 signed multiply-accumulate array, one k step per cycle
`timescale 1ns/1ps
`default_nettype none

module mm_engine (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire mm_types_pkg::buf_wr_t   buf_wr_i,
    input  wire                          buf_wr_en_i,
    input  wire                          start_i,
    output logic                         done_o,
    output mm_types_pkg::c_tile_t        tile_o
);

    localparam int N   = mm_types_pkg::SA_N;
    localparam int K_W = mm_types_pkg::ROW_AW;

    // operand rows, A by row i and B by row k
    mm_types_pkg::row_t    a_buf [N];
    mm_types_pkg::row_t    b_buf [N];
    mm_types_pkg::c_tile_t acc_q;

    logic           busy_q;
    logic [K_W-1:0] k_q;
    logic           done_q;

    // signed product, wraps into the accumulator width
    function automatic mm_types_pkg::acc_t mac_term(
        input logic signed [mm_types_pkg::ELEM_W-1:0] a,
        input logic signed [mm_types_pkg::ELEM_W-1:0] b
    );
        logic signed [2*mm_types_pkg::ELEM_W-1:0] prod;
        prod = a * b;
        return mm_types_pkg::acc_t'(prod);
    endfunction

    always_ff @(posedge clk) begin
        if (buf_wr_en_i) begin
            if (buf_wr_i.sel_b) begin
                b_buf[buf_wr_i.addr] <= buf_wr_i.data;
            end else begin
                a_buf[buf_wr_i.addr] <= buf_wr_i.data;
            end
        end
    end

    // step counter over k
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            k_q    <= '0;
            done_q <= 1'b0;
        end else begin
            // pulse lands SA_N+1 cycles after start
            done_q <= busy_q && (k_q == K_W'(N - 1));
            if (start_i) begin
                busy_q <= 1'b1;
                k_q    <= '0;
            end else if (busy_q) begin
                k_q <= k_q + 1'b1;
                if (k_q == K_W'(N - 1)) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // all 16 cells per step: acc[i][j] += A[i][k] * B[k][j]
    always_ff @(posedge clk) begin
        if (start_i) begin
            acc_q <= '0;
        end else if (busy_q) begin
            for (int i = 0; i < N; i++) begin
                for (int j = 0; j < N; j++) begin
                    acc_q[i*N+j] <= acc_q[i*N+j] + mac_term(a_buf[i][k_q], b_buf[k_q][j]);
                end
            end
        end
    end

    // held until the next start
    assign tile_o = acc_q;
    assign done_o = done_q;

endmodule

`default_nettype wire

//--- rtl/dma_reader.sv
// read side of the DMA
// two read bursts for A and B, per-operand row packing
// row writes into the engine operand buffers
`timescale 1ns/1ps
`default_nettype none

module dma_reader (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              start_i,
    input  wire [mem_bus_pkg::ADDR_W-1:0]    mat_a_addr_i,
    input  wire [mem_bus_pkg::ADDR_W-1:0]    mat_b_addr_i,
    output mem_bus_pkg::rd_addr_t            ar_o,
    output logic                             ar_valid_o,
    input  wire                              ar_ready_i,
    input  wire mem_bus_pkg::rd_data_t       r_i,
    input  wire                              r_valid_i,
    output logic                             r_ready_o,
    output mm_types_pkg::buf_wr_t            buf_wr_o,
    output logic                             buf_wr_en_o,
    output logic                             done_o
);

    localparam int ELEM_CNT_W = mm_types_pkg::ROW_AW;
    localparam int ROW_CNT_W  = mm_types_pkg::ROW_AW + 1;
    // holds the first SA_N-1 elements of a row
    localparam int SHIFT_W    = (mm_types_pkg::SA_N - 1) * mm_types_pkg::ELEM_W;

    logic                  ar_valid_q;
    logic                  ar_sel_b_q;
    logic                  r_ready_q;
    logic                  done_q;
    // index 0 packs A, index 1 packs B
    logic [SHIFT_W-1:0]    shift_q    [2];
    logic [ELEM_CNT_W-1:0] elem_cnt_q [2];
    logic [ROW_CNT_W-1:0]  row_cnt_q  [2];

    logic                  beat;
    logic                  op;
    logic                  row_end;
    logic                  last_row;
    mm_types_pkg::elem_t   elem;

    assign beat = r_valid_i && r_ready_q;
    // beat id selects the packer
    assign op   = (r_i.id == mem_bus_pkg::ID_B);
    // element in the low half, upper bits dropped
    assign elem = r_i.data[mm_types_pkg::ELEM_W-1:0];

    assign row_end  = beat && (elem_cnt_q[op] == ELEM_CNT_W'(mm_types_pkg::SA_N - 1));
    // final row of this operand while the other one is already complete
    assign last_row = row_end
                   && (row_cnt_q[op] == ROW_CNT_W'(mm_types_pkg::SA_N - 1))
                   && (row_cnt_q[!op] == ROW_CNT_W'(mm_types_pkg::SA_N));

    // address beat, A first then B
    always_comb begin
        ar_o.addr = ar_sel_b_q ? mat_b_addr_i : mat_a_addr_i;
        ar_o.id   = ar_sel_b_q ? mem_bus_pkg::ID_B : mem_bus_pkg::ID_A;
        ar_o.len  = mem_bus_pkg::len_t'(mem_bus_pkg::BURST_LEN - 1);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ar_valid_q <= 1'b0;
            ar_sel_b_q <= 1'b0;
            r_ready_q  <= 1'b0;
            done_q     <= 1'b0;
            for (int op_i = 0; op_i < 2; op_i++) begin
                elem_cnt_q[op_i] <= '0;
                row_cnt_q[op_i]  <= '0;
            end
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                ar_valid_q <= 1'b1;
                ar_sel_b_q <= 1'b0;
                r_ready_q  <= 1'b1;
                for (int op_i = 0; op_i < 2; op_i++) begin
                    elem_cnt_q[op_i] <= '0;
                    row_cnt_q[op_i]  <= '0;
                end
            end else begin
                // A accepted, switch to B; B accepted, drop valid
                if (ar_valid_q && ar_ready_i) begin
                    if (ar_sel_b_q) begin
                        ar_valid_q <= 1'b0;
                    end
                    ar_sel_b_q <= 1'b1;
                end
                // element counter wraps each row
                if (beat) begin
                    elem_cnt_q[op] <= elem_cnt_q[op] + 1'b1;
                    if (row_end) begin
                        row_cnt_q[op] <= row_cnt_q[op] + 1'b1;
                    end
                end
                if (last_row) begin
                    r_ready_q <= 1'b0;
                    done_q    <= 1'b1;
                end
            end
        end
    end

    // new element enters at the top, element 0 ends up lowest
    always_ff @(posedge clk) begin
        if (beat) begin
            shift_q[op] <= {elem, shift_q[op][SHIFT_W-1:mm_types_pkg::ELEM_W]};
        end
    end

    // row write in the same cycle as its last beat
    always_comb begin
        buf_wr_o.sel_b = op;
        buf_wr_o.addr  = row_cnt_q[op][mm_types_pkg::ROW_AW-1:0];
        buf_wr_o.data  = {elem, shift_q[op]};
    end

    assign buf_wr_en_o = row_end;
    assign ar_valid_o  = ar_valid_q;
    assign r_ready_o   = r_ready_q;
    assign done_o      = done_q;

endmodule

`default_nettype wire

//--- rtl/mem_bus_pkg.sv
// memory bus definitions
// widths, burst length, read ids
// packed payloads of the ar, r, aw and w channels
`default_nettype none

package mem_bus_pkg;

    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int LEN_W     = 8;
    localparam int ID_W      = 1;
    localparam int BURST_LEN = 16;

    typedef logic [LEN_W-1:0] len_t;
    typedef logic [ID_W-1:0]  id_t;

    // one id per operand
    localparam id_t ID_A = 1'b0;
    localparam id_t ID_B = 1'b1;

    // read address, len is beats minus one
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        id_t               id;
        len_t              len;
    } rd_addr_t;

    // read data, id picks the operand
    typedef struct packed {
        logic [DATA_W-1:0] data;
        id_t               id;
        logic              last;
    } rd_data_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        len_t              len;
    } wr_addr_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } wr_data_t;

endpackage

`default_nettype wire

//--- rtl/mm_types_pkg.sv
// matrix-multiply data types
// array size, element and accumulator widths
// operand row, buffer write and result tile layouts
`default_nettype none

package mm_types_pkg;

    // array size, also the fixed matrix dimension
    localparam int SA_N   = 4;
    localparam int ELEM_W = 16;
    // sums wrap modulo 2^ACC_W
    localparam int ACC_W  = 32;
    localparam int ROW_AW = $clog2(SA_N);

    typedef logic [ELEM_W-1:0] elem_t;
    typedef logic [ACC_W-1:0]  acc_t;

    // element 0 in the low bits
    typedef elem_t [SA_N-1:0] row_t;

    // one row into operand buffer A or B
    typedef struct packed {
        logic              sel_b;
        logic [ROW_AW-1:0] addr;
        row_t              data;
    } buf_wr_t;

    // row-major, accumulator [i][j] at index i*SA_N+j
    typedef acc_t [SA_N*SA_N-1:0] c_tile_t;

endpackage

`default_nettype wire
